// ==== common/gpio_defines.svh ====
/*
 * GPIO LED controller constants
 * LED count, datapath widths, USI block address and CSR offsets
 */
`ifndef GPIO_DEFINES_SVH
`define GPIO_DEFINES_SVH

// Sizes
`define GPIO_LED_NUM        5
`define GPIO_DUTY_W         8
`define GPIO_IV_W           32
`define USI_BUS_W           32

// Block select on the USI bus
`define GPIO_BLOCK_ADRS     8'h01

// CSR offsets; the array bases take the LED index added
`define GPIO_CSR_EN         8'h00
`define GPIO_CSR_MODE       8'h01
`define GPIO_CSR_DUTY       8'h10
`define GPIO_CSR_IV         8'h20

// RGB group on LEDs 2 to 4 is active low
`define GPIO_LED_ACTIVE_LOW 5'b11100

`endif

// ==== common/GpioPkg.sv ====
/*
 * GPIO package
 * USI bus write bundle and the address word with its field view
 */
`include "gpio_defines.svh"

package GpioPkg;

	// Address word seen raw by the master and split by the decoders
	typedef union packed
	{
		logic [`USI_BUS_W-1:0] raw;
		struct packed
		{
			// Upper half not decoded
			logic [`USI_BUS_W-17:0] rsvd;
			logic [7:0]             blockAdrs;
			logic [7:0]             csrOfs;
		} field;
	} usiAdrsT;

	// Master to slave direction of USI
	typedef struct packed
	{
		logic                  wrEn;
		usiAdrsT               adrs;
		logic [`USI_BUS_W-1:0] wrData;
	} usiWriteT;

endpackage

// ==== gpio/DutyGenerator.sv ====
/*
 * Duty generator for one LED
 * Free-running PWM compare and a blink interval tick
 */
module DutyGenerator #(
	parameter int dutyW = 8,
	parameter int ivW   = 32
)(
	input  logic             iSCLK,
	input  logic             arstN,
	input  logic             enable,
	input  logic [dutyW-1:0] dutyRatio,
	input  logic [ivW-1:0]   ivTimer,
	output logic             pwm,
	output logic             ivTick
);

//------------------------------
// PWM
//------------------------------
logic [dutyW-1:0] pwmCnt;

// Wrap after 2**dutyW cycles sets the PWM period
always_ff @(posedge iSCLK or negedge arstN)
begin
	if (!arstN)
	begin
		pwmCnt <= '0;
	end
	else if (!enable)
	begin
		pwmCnt <= '0;
	end
	else
	begin
		pwmCnt <= pwmCnt + 1'b1;
	end
end

// High for exactly dutyRatio counts per period
assign pwm = enable && (pwmCnt < dutyRatio);

//------------------------------
// Interval timer
//------------------------------
logic [ivW-1:0] ivCnt;

assign ivTick = enable && (ivCnt == ivTimer);

// Restart on the tick, so ticks are ivTimer+1 apart
always_ff @(posedge iSCLK or negedge arstN)
begin
	if (!arstN)
	begin
		ivCnt <= '0;
	end
	else if (!enable || ivTick)
	begin
		ivCnt <= '0;
	end
	else
	begin
		ivCnt <= ivCnt + 1'b1;
	end
end

endmodule

// ==== gpio/GpioCsr.sv ====
/*
 * GPIO control registers
 * Decodes USI writes into the LED CSRs and returns a registered read word
 */
`include "gpio_defines.svh"

module GpioCsr
	import GpioPkg::*;
(
	input  logic                                        iSCLK,
	input  logic                                        arstN,
	input  usiWriteT                                    usiWr,
	output logic [`USI_BUS_W-1:0]                       rdData,
	output logic [`GPIO_LED_NUM-1:0]                    ledEn,
	output logic [1:0]                                  flashMode,
	output logic [`GPIO_LED_NUM-1:0][`GPIO_DUTY_W-1:0]  dutyRatio,
	output logic [`GPIO_LED_NUM-1:0][`GPIO_IV_W-1:0]    ivTimer
);

//------------------------------
// Address decode
//------------------------------
logic       blockHit;
logic [7:0] csrOfs;
logic       wrHit;

assign blockHit = (usiWr.adrs.field.blockAdrs == `GPIO_BLOCK_ADRS);
assign csrOfs   = usiWr.adrs.field.csrOfs;
assign wrHit    = usiWr.wrEn && blockHit;

//------------------------------
// Register write
//------------------------------
always_ff @(posedge iSCLK or negedge arstN)
begin
	if (!arstN)
	begin
		ledEn     <= '0;
		flashMode <= '0;
		dutyRatio <= '0;
		ivTimer   <= '0;
	end
	else if (wrHit)
	begin
		// Narrow registers keep the low bits
		if (csrOfs == `GPIO_CSR_EN)
		begin
			ledEn <= usiWr.wrData[`GPIO_LED_NUM-1:0];
		end
		if (csrOfs == `GPIO_CSR_MODE)
		begin
			flashMode <= usiWr.wrData[1:0];
		end
		for (int i = 0; i < `GPIO_LED_NUM; i++)
		begin
			if (csrOfs == 8'(`GPIO_CSR_DUTY + i))
			begin
				dutyRatio[i] <= usiWr.wrData[`GPIO_DUTY_W-1:0];
			end
			if (csrOfs == 8'(`GPIO_CSR_IV + i))
			begin
				ivTimer[i] <= usiWr.wrData[`GPIO_IV_W-1:0];
			end
		end
	end
end

//------------------------------
// Read mux
//------------------------------
logic [`USI_BUS_W-1:0] rdNext;

always_comb
begin
	rdNext = '0;
	// Foreign blocks and unknown offsets read zero so buses can be ORed
	if (blockHit)
	begin
		if (csrOfs == `GPIO_CSR_EN)
		begin
			rdNext[`GPIO_LED_NUM-1:0] = ledEn;
		end
		if (csrOfs == `GPIO_CSR_MODE)
		begin
			rdNext[1:0] = flashMode;
		end
		for (int i = 0; i < `GPIO_LED_NUM; i++)
		begin
			if (csrOfs == 8'(`GPIO_CSR_DUTY + i))
			begin
				rdNext[`GPIO_DUTY_W-1:0] = dutyRatio[i];
			end
			if (csrOfs == 8'(`GPIO_CSR_IV + i))
			begin
				rdNext[`GPIO_IV_W-1:0] = ivTimer[i];
			end
		end
	end
end

// One cycle read latency
always_ff @(posedge iSCLK or negedge arstN)
begin
	if (!arstN)
	begin
		rdData <= '0;
	end
	else
	begin
		rdData <= rdNext;
	end
end

endmodule

// ==== gpio/GpioBlock.sv ====
/*
 * GPIO LED block
 * USI mapped CSRs, one duty generator per LED and the mode driven LED register
 */
`include "gpio_defines.svh"

module GpioBlock
	import GpioPkg::*;
(
	input  logic                     iSCLK,
	input  logic                     arstN,
	input  usiWriteT                 usiWr,
	output logic [`USI_BUS_W-1:0]    rdData,
	output logic [`GPIO_LED_NUM-1:0] led
);

localparam logic [1:0] modeStatic = 2'd0;
localparam logic [1:0] modeBlink  = 2'd1;
localparam logic [1:0] modePwm    = 2'd2;

//------------------------------
// CSR space
//------------------------------
logic [`GPIO_LED_NUM-1:0]                   ledEn;
logic [1:0]                                 flashMode;
logic [`GPIO_LED_NUM-1:0][`GPIO_DUTY_W-1:0] dutyRatio;
logic [`GPIO_LED_NUM-1:0][`GPIO_IV_W-1:0]   ivTimer;

GpioCsr uCsr (
	.iSCLK     (iSCLK),
	.arstN     (arstN),
	.usiWr     (usiWr),
	.rdData    (rdData),
	.ledEn     (ledEn),
	.flashMode (flashMode),
	.dutyRatio (dutyRatio),
	.ivTimer   (ivTimer)
);

//------------------------------
// Generators
//------------------------------
logic                     timedMode;
logic [`GPIO_LED_NUM-1:0] genEn;
logic [`GPIO_LED_NUM-1:0] pwm;
logic [`GPIO_LED_NUM-1:0] ivTick;

// Counters only run for blink or PWM on enabled LEDs
assign timedMode = (flashMode == modeBlink) || (flashMode == modePwm);
assign genEn     = ledEn & {`GPIO_LED_NUM{timedMode}};

for (genvar i = 0; i < `GPIO_LED_NUM; i++)
begin : gDuty
	DutyGenerator #(
		.dutyW (`GPIO_DUTY_W),
		.ivW   (`GPIO_IV_W)
	) uDuty (
		.iSCLK     (iSCLK),
		.arstN     (arstN),
		.enable    (genEn[i]),
		.dutyRatio (dutyRatio[i]),
		.ivTimer   (ivTimer[i]),
		.pwm       (pwm[i]),
		.ivTick    (ivTick[i])
	);
end

//------------------------------
// LED drive
//------------------------------
// Logical on state with polarity applied at the port
logic [`GPIO_LED_NUM-1:0] ledOn;

always_ff @(posedge iSCLK or negedge arstN)
begin
	if (!arstN)
	begin
		ledOn <= '0;
	end
	else
	begin
		case (flashMode)
			modeStatic:
			begin
				ledOn <= ledEn;
			end
			modeBlink:
			begin
				// Toggle on tick and force disabled LEDs off
				ledOn <= (ledOn ^ ivTick) & ledEn;
			end
			modePwm:
			begin
				ledOn <= pwm;
			end
			default:
			begin
				// Mode 3 behaves as static
				ledOn <= ledEn;
			end
		endcase
	end
end

assign led = ledOn ^ `GPIO_LED_ACTIVE_LOW;

endmodule

// ==== test/GpioBlock_assert.sv ====
/*
 * GPIO block assertions
 * Bus read, LED mode and reset rules, bound into GpioBlock
 */
`include "gpio_defines.svh"

module GpioBlockAssert
	import GpioPkg::*;
(
	input logic                                       iSCLK,
	input logic                                       arstN,
	input usiWriteT                                   usiWr,
	input logic [`USI_BUS_W-1:0]                      rdData,
	input logic [`GPIO_LED_NUM-1:0]                   led,
	input logic [`GPIO_LED_NUM-1:0]                   ledEn,
	input logic [1:0]                                 flashMode,
	input logic [`GPIO_LED_NUM-1:0][`GPIO_DUTY_W-1:0] dutyRatio,
	input logic [`GPIO_LED_NUM-1:0][`GPIO_IV_W-1:0]   ivTimer
);

timeunit 1ns;
timeprecision 100ps;

int failCnt = 0;

logic                           wrSeen;
logic [`GPIO_LED_NUM-1:0]       ledOn;
logic [`GPIO_LED_NUM-1:0]       ledQ;
logic [`GPIO_LED_NUM-1:0]       blinkNow;
logic [`GPIO_LED_NUM-1:0]       blinkQ;
logic [`GPIO_LED_NUM-1:0]       pwmQ;
logic [`GPIO_LED_NUM-1:0]       seen;
logic [`GPIO_LED_NUM-1:0][31:0] gap;
logic [`GPIO_LED_NUM-1:0][7:0]  win;
logic [`GPIO_LED_NUM-1:0][8:0]  onCnt;

assign ledOn    = led ^ `GPIO_LED_ACTIVE_LOW;
assign blinkNow = ledEn & {`GPIO_LED_NUM{flashMode == 2'd1}};

//------------------------------
// Toggle gaps and PWM windows
//------------------------------
always_ff @(posedge iSCLK or negedge arstN)
begin
	if (!arstN)
	begin
		wrSeen <= 1'b0;
		ledQ   <= `GPIO_LED_ACTIVE_LOW;
		blinkQ <= '0;
		pwmQ   <= '0;
		seen   <= '0;
		gap    <= '0;
		win    <= '0;
		onCnt  <= '0;
	end
	else
	begin
		wrSeen <= wrSeen | usiWr.wrEn;
		ledQ   <= led;
		blinkQ <= blinkNow;
		pwmQ   <= ledEn & {`GPIO_LED_NUM{flashMode == 2'd2}};
		for (int i = 0; i < `GPIO_LED_NUM; i++)
		begin
			// A gap only counts inside one unbroken blink run
			if (!(blinkNow[i] && blinkQ[i]))
			begin
				seen[i] <= 1'b0;
				gap[i]  <= '0;
			end
			else if (led[i] != ledQ[i])
			begin
				seen[i] <= 1'b1;
				gap[i]  <= 32'd1;
			end
			else
				gap[i] <= gap[i] + 1'b1;
			// 256 sample windows while the generator runs
			win[i]   <= pwmQ[i] ? win[i] + 1'b1 : '0;
			onCnt[i] <= (!pwmQ[i] || win[i] == 8'd255) ? '0 : onCnt[i] + ledOn[i];
		end
	end
end

foreignRead: assert property (@(posedge iSCLK) disable iff (!arstN)
	(usiWr.adrs.field.blockAdrs != `GPIO_BLOCK_ADRS) |=> (rdData == '0))
	else begin failCnt++; $error("Read of a foreign block returned %h", rdData); end

staticLed: assert property (@(posedge iSCLK) disable iff (!arstN)
	(flashMode == 2'd0 || flashMode == 2'd3) |=> (led == ($past(ledEn) ^ `GPIO_LED_ACTIVE_LOW)))
	else begin failCnt++; $error("Static mode led %b", led); end

blinkOff: assert property (@(posedge iSCLK) disable iff (!arstN)
	(flashMode == 2'd1) |=> ((ledOn & ~$past(ledEn)) == '0))
	else begin failCnt++; $error("Disabled LED lit in blink mode, led %b", led); end

// Held through reset and until the first write
resetState: assert property (@(posedge iSCLK)
	!wrSeen |-> (led == `GPIO_LED_ACTIVE_LOW && rdData == '0))
	else begin failCnt++; $error("Reset state wrong, led %b rdData %h", led, rdData); end

for (genvar i = 0; i < `GPIO_LED_NUM; i++)
begin : gLed
	blinkPeriod: assert property (@(posedge iSCLK) disable iff (!arstN)
		(blinkNow[i] && blinkQ[i] && seen[i] && led[i] != ledQ[i])
		|-> (gap[i] == ivTimer[i] + 1))
		else begin failCnt++; $error("LED %0d toggled after %0d cycles", i, gap[i]); end

	pwmDuty: assert property (@(posedge iSCLK) disable iff (!arstN)
		(pwmQ[i] && win[i] == 8'd255) |-> ((onCnt[i] + ledOn[i]) == dutyRatio[i]))
		else begin failCnt++; $error("LED %0d on for %0d of 256 cycles", i, onCnt[i]); end
end

endmodule

bind GpioBlock GpioBlockAssert uAssert (
	.iSCLK     (iSCLK),
	.arstN     (arstN),
	.usiWr     (usiWr),
	.rdData    (rdData),
	.led       (led),
	.ledEn     (ledEn),
	.flashMode (flashMode),
	.dutyRatio (dutyRatio),
	.ivTimer   (ivTimer)
);

// ==== test/GpioBlockTb.sv ====
/*
 * GPIO block testbench
 * USI writes and reads against a register model, LED modes left to the assertions
 */
`include "gpio_defines.svh"

module GpioBlockTb
	import GpioPkg::*;
();

timeunit 1ns;
timeprecision 100ps;

logic                     iSCLK;
logic                     arstN;
usiWriteT                 usiWr;
logic [`USI_BUS_W-1:0]    rdData;
logic [`GPIO_LED_NUM-1:0] led;

int seed       = 79;
int errCnt     = 0;
int timeoutCnt = 0;

// Register model
logic [`GPIO_LED_NUM-1:0] expEn;
logic [`GPIO_DUTY_W-1:0]  expDuty [`GPIO_LED_NUM];
logic [`GPIO_IV_W-1:0]    expIv [`GPIO_LED_NUM];

GpioBlock dut (
	.iSCLK  (iSCLK),
	.arstN  (arstN),
	.usiWr  (usiWr),
	.rdData (rdData),
	.led    (led)
);

initial
begin
	iSCLK = 1'b0;
	forever #4 iSCLK = ~iSCLK;
end

task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] got);
	if (got !== exp)
	begin
		errCnt++;
		$display("FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
	end
endtask

task automatic busWrite(input logic [7:0] blk, input logic [7:0] ofs, input logic [31:0] data);
	@(posedge iSCLK);
	usiWr.wrEn     <= 1'b1;
	usiWr.adrs.raw <= {16'h0000, blk, ofs};
	usiWr.wrData   <= data;
	@(posedge iSCLK);
	usiWr.wrEn     <= 1'b0;
endtask

// Address sampled one edge after driving and data registered on that edge
task automatic busRead(input logic [7:0] blk, input logic [7:0] ofs,
	input logic [31:0] exp, input string name);
	@(posedge iSCLK);
	usiWr.adrs.raw <= {16'h0000, blk, ofs};
	repeat (2) @(posedge iSCLK);
	checkValue(name, exp, rdData);
endtask

task automatic waitToggle(input int idx, input int limit);
	logic start;
	int   cnt;
	start = led[idx];
	cnt   = 0;
	while (led[idx] == start && cnt < limit)
	begin
		@(posedge iSCLK);
		cnt++;
	end
	if (led[idx] == start)
	begin
		timeoutCnt++;
		$display("Timeout: LED %0d did not toggle within %0d cycles", idx, limit);
	end
endtask

initial
begin
	logic [31:0] data;
	arstN = 1'b0;
	usiWr = '0;
	repeat (8) @(posedge iSCLK);
	arstN <= 1'b1;
	busRead(`GPIO_BLOCK_ADRS, `GPIO_CSR_EN, '0, "rdData after reset");

	//------------------------------
	// Readback of every CSR
	//------------------------------
	data = $random(seed);
	busWrite(`GPIO_BLOCK_ADRS, `GPIO_CSR_EN, data);
	expEn = data[`GPIO_LED_NUM-1:0];
	busRead(`GPIO_BLOCK_ADRS, `GPIO_CSR_EN, 32'(expEn), "ledEn");
	for (int i = 0; i < `GPIO_LED_NUM; i++)
	begin
		data = $random(seed);
		busWrite(`GPIO_BLOCK_ADRS, 8'(`GPIO_CSR_DUTY + i), data);
		expDuty[i] = data[`GPIO_DUTY_W-1:0];
		busRead(`GPIO_BLOCK_ADRS, 8'(`GPIO_CSR_DUTY + i), 32'(expDuty[i]),
			$sformatf("dutyRatio[%0d]", i));
		data = $random(seed);
		busWrite(`GPIO_BLOCK_ADRS, 8'(`GPIO_CSR_IV + i), data);
		expIv[i] = data;
		busRead(`GPIO_BLOCK_ADRS, 8'(`GPIO_CSR_IV + i), expIv[i], $sformatf("ivTimer[%0d]", i));
	end
	// Mode last, so no timed mode sees a register change
	data = $random(seed);
	busWrite(`GPIO_BLOCK_ADRS, `GPIO_CSR_MODE, data);
	busRead(`GPIO_BLOCK_ADRS, `GPIO_CSR_MODE, 32'(data[1:0]), "flashMode");

	// Foreign block aimed at a full width register, then an unknown offset
	busRead(8'h02, `GPIO_CSR_IV, '0, "rdData foreign block");
	busWrite(8'h02, `GPIO_CSR_EN, ~32'(expEn));
	busRead(`GPIO_BLOCK_ADRS, `GPIO_CSR_EN, 32'(expEn), "ledEn after foreign write");
	busRead(`GPIO_BLOCK_ADRS, 8'h3f, '0, "rdData unknown offset");

	// Static, modes 0 and 3
	for (int m = 0; m < 4; m += 3)
	begin
		busWrite(`GPIO_BLOCK_ADRS, `GPIO_CSR_MODE, m);
		data = $random(seed);
		busWrite(`GPIO_BLOCK_ADRS, `GPIO_CSR_EN, data);
		expEn = data[`GPIO_LED_NUM-1:0];
		repeat (2) @(posedge iSCLK);
		checkValue("led", 32'(expEn ^ `GPIO_LED_ACTIVE_LOW), 32'(led));
	end

	//------------------------------
	// Blink then PWM
	//------------------------------
	busWrite(`GPIO_BLOCK_ADRS, `GPIO_CSR_MODE, 32'd0);
	for (int i = 0; i < `GPIO_LED_NUM; i++)
		busWrite(`GPIO_BLOCK_ADRS, 8'(`GPIO_CSR_IV + i), (i == 2) ? 32'd6 : 32'd3);
	busWrite(`GPIO_BLOCK_ADRS, `GPIO_CSR_EN, 32'b10110);
	busWrite(`GPIO_BLOCK_ADRS, `GPIO_CSR_MODE, 32'd1);
	for (int k = 0; k < 4; k++)
	begin
		waitToggle(1, 20);
		waitToggle(2, 20);
		waitToggle(4, 20);
	end

	busWrite(`GPIO_BLOCK_ADRS, `GPIO_CSR_MODE, 32'd0);
	busWrite(`GPIO_BLOCK_ADRS, `GPIO_CSR_EN, 32'b11111);
	for (int i = 0; i < `GPIO_LED_NUM; i++)
	begin
		data = (i == 1) ? 32'h80 : (i == 2) ? 32'h0 : (i == 4) ? 32'hff : $random(seed);
		busWrite(`GPIO_BLOCK_ADRS, 8'(`GPIO_CSR_DUTY + i), data);
	end
	busWrite(`GPIO_BLOCK_ADRS, `GPIO_CSR_MODE, 32'd2);
	repeat (600) @(posedge iSCLK);
	busWrite(`GPIO_BLOCK_ADRS, `GPIO_CSR_MODE, 32'd0);
	repeat (4) @(posedge iSCLK);

	$display("Summary: %0d mismatches, %0d timeouts, %0d assertion failures",
		errCnt, timeoutCnt, dut.uAssert.failCnt);
	if (errCnt + timeoutCnt + dut.uAssert.failCnt == 0)
	begin
		$display("=== PASS ===");
	end
	else
	begin
		$display("=== FAIL ===");
	end
	$finish;
end

endmodule

// ==== project.f ====
+incdir+common
common/GpioPkg.sv
gpio/DutyGenerator.sv
gpio/GpioCsr.sv
gpio/GpioBlock.sv
test/GpioBlock_assert.sv
test/GpioBlockTb.sv
